// ==== vlog.f ====
logic/kbd_pkg.sv
logic/ps2_rx.sv
logic/ps2_idle_timer.sv
logic/key_decoder_fsm.sv
logic/seg7.sv
logic/kbd_display_top.sv
verif/kbd_display_props.sv
verif/kbd_display_tb.sv

// ==== verif/kbd_display_tb.sv ====
module kbd_display_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import kbd_pkg::*;

    localparam int PS2_HALF       = 50;  // system cycles per PS/2 half-period
    localparam int SETTLE_CYCLES  = 20;
    localparam int TIMEOUT_CYCLES = (30 * 11 * 100 + PS2_IDLE_CYCLES) * 2;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [7:0] seg1;
    logic [7:0] seg2;

    integer     seed;
    int         cycle_cnt;
    logic [7:0] exp_code;
    logic       exp_blank;
    logic       break_seen;
    logic [7:0] code;
    logic [7:0] digit_tbl [16];

    kbd_display_top DUT (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2)
    );

    bind kbd_display_top kbd_display_props u_props (
        .clk        (clk),
        .rst        (rst),
        .seg1       (seg1),
        .seg2       (seg2),
        .ready      (ready),
        .nextdata_n (nextdata_n)
    );

    // active low bits {dp, g, f, e, d, c, b, a}
    initial
    begin
        digit_tbl[0]  = 8'b1100_0000;  // a b c d e f
        digit_tbl[1]  = 8'b1111_1001;  // b c
        digit_tbl[2]  = 8'b1010_0100;
        digit_tbl[3]  = 8'b1011_0000;
        digit_tbl[4]  = 8'b1001_1001;
        digit_tbl[5]  = 8'b1001_0010;
        digit_tbl[6]  = 8'b1000_0010;
        digit_tbl[7]  = 8'b1111_1000;
        digit_tbl[8]  = 8'b1000_0000;
        digit_tbl[9]  = 8'b1001_0000;
        digit_tbl[10] = 8'b1000_1000;  // A
        digit_tbl[11] = 8'b1000_0011;  // lower case b
        digit_tbl[12] = 8'b1100_0110;
        digit_tbl[13] = 8'b1010_0001;  // lower case d
        digit_tbl[14] = 8'b1000_0110;
        digit_tbl[15] = 8'b1000_1110;
    end

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // data changes while the PS/2 clock is high
    task automatic drive_frame(input logic [7:0] value, input bit bad_parity, input int nbits);
        ps2_frame_u frame;
        frame.f.start  = 1'b0;
        frame.f.data   = value;
        frame.f.parity = ~(^value) ^ bad_parity;  // odd parity
        frame.f.stop   = 1'b1;
        for (int i = 0; i < nbits; i++)
        begin
            ps2_dat = frame.raw[i];
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    // good frame plus update of the expected key state
    task automatic send_key(input logic [7:0] value);
        drive_frame(value, 1'b0, FRAME_BITS);
        if (value == BREAK_PREFIX)
            break_seen = 1'b1;
        else if (break_seen)
        begin
            break_seen = 1'b0;
            exp_blank  = 1'b1;
        end
        else
        begin
            exp_code  = value;
            exp_blank = 1'b0;
        end
    endtask

    function automatic logic [7:0] random_code();
        logic [7:0] value;
        value = BREAK_PREFIX;
        while (value == BREAK_PREFIX)
            value = 8'($random(seed));
        return value;
    endfunction

    function automatic logic [7:0] expected_seg(input logic [3:0] nibble);
        return exp_blank ? SEG_BLANK : digit_tbl[nibble];
    endfunction

    task automatic check_display();
        logic [7:0] exp1;
        logic [7:0] exp2;
        exp1 = expected_seg(exp_code[3:0]);
        exp2 = expected_seg(exp_code[7:4]);
        assert (seg1 === exp1)
        else
        begin
            $display("mismatch at %0t: seg1 expected %h actual %h", $time, exp1, seg1);
            $display("TEST FAILED");
            $fatal(1, "display check failed");
        end
        assert (seg2 === exp2)
        else
        begin
            $display("mismatch at %0t: seg2 expected %h actual %h", $time, exp2, seg2);
            $display("TEST FAILED");
            $fatal(1, "display check failed");
        end
    endtask

    task automatic settle_and_check();
        wait_cycles(SETTLE_CYCLES);
        check_display();
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES && DUT.u_props.fail_cnt == 0)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        if (DUT.u_props.fail_cnt != 0)
            $display("a bound assertion failed at %0t", $time);
        else
            $display("run timed out after %0d cycles", cycle_cnt);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    end

    initial
    begin
        rst        = 1'b0;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        seed       = 32'h6050;
        exp_code   = 8'h00;
        exp_blank  = 1'b1;
        break_seen = 1'b0;
        wait_cycles(8);
        rst = 1'b1;
        settle_and_check();  // blank after reset

        repeat (10)
        begin
            send_key(random_code());
            settle_and_check();
        end

        // release of the shown key and a new press
        code = exp_code;
        send_key(BREAK_PREFIX);
        settle_and_check();
        send_key(code);
        settle_and_check();
        send_key(random_code());
        settle_and_check();

        // bad parity frame is dropped
        drive_frame(random_code(), 1'b1, FRAME_BITS);
        settle_and_check();
        send_key(random_code());
        settle_and_check();

        // PS/2 clock stalls after 5 bits
        drive_frame(random_code(), 1'b0, 5);
        wait_cycles(PS2_IDLE_CYCLES + SETTLE_CYCLES);
        check_display();
        send_key(random_code());
        settle_and_check();

        // make and break prefix back to back
        send_key(random_code());
        send_key(BREAK_PREFIX);
        settle_and_check();
        send_key(random_code());
        settle_and_check();

        wait_cycles(2);
        if (DUT.u_props.fail_cnt == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("TEST FAILED");
            $fatal(1, "bound assertion failed");
        end
    end

endmodule

// ==== verif/kbd_display_props.sv ====
module kbd_display_props (
    input logic       clk,
    input logic       rst,
    input logic [7:0] seg1,
    input logic [7:0] seg2,
    input logic       ready,
    input logic       nextdata_n
);
    timeunit 1ns;
    timeprecision 1ps;
    import kbd_pkg::*;

    int fail_cnt = 0;  // failed assertion count

    blank_in_reset: assert property (@(posedge clk)
        !rst |=> (seg1 == SEG_BLANK) && (seg2 == SEG_BLANK))
    else
    begin
        fail_cnt++;
        $error("digits are not blank while reset is held");
    end

    // digits blank together, lit together
    digits_agree: assert property (@(posedge clk) disable iff (!rst)
        (seg1 == SEG_BLANK) == (seg2 == SEG_BLANK))
    else
    begin
        fail_cnt++;
        $error("one digit is blank while the other is lit");
    end

    outputs_known: assert property (@(posedge clk) disable iff (!rst)
        !$isunknown({seg1, seg2}))
    else
    begin
        fail_cnt++;
        $error("segment outputs are unknown after reset");
    end

    pop_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |=> nextdata_n)
    else
    begin
        fail_cnt++;
        $error("pop strobe held low for two cycles");
    end

    pop_needs_ready: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> ready)
    else
    begin
        fail_cnt++;
        $error("pop strobe low while the FIFO is empty");
    end

endmodule

// ==== logic/kbd_display_top.sv ====
module kbd_display_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg1,
    output logic [7:0] seg2
);

    logic [7:0] data;
    logic       ready;
    logic       nextdata_n;
    logic       busy;
    logic       fall;
    logic       abort;
    logic [7:0] keyvalue;
    logic       clear;

    ps2_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_dat),
        .nextdata_n (nextdata_n),
        .abort      (abort),
        .data       (data),
        .ready      (ready),
        .overflow   (),  // internal flag only
        .busy       (busy),
        .fall       (fall)
    );

    ps2_idle_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .busy  (busy),
        .fall  (fall),
        .abort (abort)
    );

    key_decoder_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .data       (data),
        .ready      (ready),
        .nextdata_n (nextdata_n),
        .keyvalue   (keyvalue),
        .clear      (clear)
    );

    seg7 u_seg_lo (
        .num     (keyvalue[3:0]),
        .clear   (clear),
        .seg_out (seg1)
    );

    seg7 u_seg_hi (
        .num     (keyvalue[7:4]),
        .clear   (clear),
        .seg_out (seg2)
    );

endmodule

// ==== logic/seg7.sv ====
module seg7 (
    input  logic [3:0] num,
    input  logic       clear,
    output logic [7:0] seg_out
);
    import kbd_pkg::*;

    // bit order {dp, g, f, e, d, c, b, a}, low = lit
    always_comb
    begin
        if (clear)
            seg_out = SEG_BLANK;
        else
        begin
            case (num)
                4'h0: seg_out = 8'hC0;
                4'h1: seg_out = 8'hF9;
                4'h2: seg_out = 8'hA4;
                4'h3: seg_out = 8'hB0;
                4'h4: seg_out = 8'h99;
                4'h5: seg_out = 8'h92;
                4'h6: seg_out = 8'h82;
                4'h7: seg_out = 8'hF8;
                4'h8: seg_out = 8'h80;
                4'h9: seg_out = 8'h90;
                4'hA: seg_out = 8'h88;
                4'hB: seg_out = 8'h83;
                4'hC: seg_out = 8'hC6;
                4'hD: seg_out = 8'hA1;
                4'hE: seg_out = 8'h86;
                default: seg_out = 8'h8E;
            endcase
        end
    end

endmodule

// ==== logic/key_decoder_fsm.sv ====
module key_decoder_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       ready,
    output logic       nextdata_n,
    output logic [7:0] keyvalue,
    output logic       clear
);
    import kbd_pkg::*;

    kbd_state_e state;
    kbd_state_e state_next;

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (ready)
                    state_next = FETCH;
            FETCH:
                if (data == BREAK_PREFIX)
                    state_next = BREAK_WAIT;
                else
                    state_next = MAKE;
            MAKE:
                state_next = IDLE;
            BREAK_WAIT:
                state_next = BREAK_CODE;  // prefix popped here
            BREAK_CODE:
                if (ready)
                    state_next = RELEASE;
            RELEASE:
                state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    // strobe is low exactly while in a popping state
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            nextdata_n <= 1'b1;
            keyvalue   <= 8'd0;
            clear      <= 1'b1;
        end
        else
        begin
            nextdata_n <= !(state_next inside {MAKE, BREAK_WAIT, RELEASE});
            if (state == MAKE)
            begin
                keyvalue <= data;
                clear    <= 1'b0;
            end
            else if (state == RELEASE)
                clear <= 1'b1;  // key released, blank digits
        end
    end

endmodule

// ==== logic/ps2_idle_timer.sv ====
module ps2_idle_timer (
    input  logic clk,
    input  logic rst,
    input  logic busy,
    input  logic fall,
    output logic abort
);
    import kbd_pkg::*;

    logic [IDLE_CNT_W-1:0] idle_cnt;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            idle_cnt <= '0;
            abort    <= 1'b0;
        end
        else if (!busy || fall)
        begin
            idle_cnt <= '0;  // activity seen
            abort    <= 1'b0;
        end
        else if (idle_cnt == IDLE_CNT_W'(PS2_IDLE_CYCLES - 1))
        begin
            idle_cnt <= '0;
            abort    <= 1'b1;  // clock stalled mid-frame
        end
        else
        begin
            idle_cnt <= idle_cnt + 1'b1;
            abort    <= 1'b0;
        end
    end

endmodule

// ==== logic/ps2_rx.sv ====
module ps2_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       nextdata_n,
    input  logic       abort,
    output logic [7:0] data,
    output logic       ready,
    output logic       overflow,
    output logic       busy,
    output logic       fall
);
    import kbd_pkg::*;

    logic [1:0]       clk_sync;
    logic [1:0]       dat_sync;
    logic             clk_prev;
    logic [3:0]       bit_cnt;
    ps2_frame_u       frame;
    ps2_frame_u       frame_next;
    logic             frame_good;
    logic             last_bit;
    logic             wr_en;
    logic [7:0]       wr_data;
    logic [7:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW:0] w_ptr;
    logic [FIFO_AW:0] r_ptr;
    logic             full;
    logic             pop;

    // lines idle high, so reset the synchronizers to 1
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_data};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    assign frame_next.raw = {dat_sync[1], frame.raw[FRAME_BITS-1:1]};  // lsb first
    assign last_bit       = (bit_cnt == 4'(FRAME_BITS - 1));
    assign frame_good     = (frame_next.f.start == 1'b0) && frame_next.f.stop
                            && (^{frame_next.f.parity, frame_next.f.data});  // odd parity
    assign busy           = (bit_cnt != 4'd0);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt <= 4'd0;
            wr_en   <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            if (abort)
                bit_cnt <= 4'd0;  // drop partial frame
            else if (fall)
            begin
                if (last_bit)
                begin
                    bit_cnt <= 4'd0;
                    wr_en   <= frame_good;
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= frame_next;
        if (fall && last_bit)
            wr_data <= frame_next.f.data;
    end

    assign ready = (w_ptr != r_ptr);
    assign full  = (w_ptr[FIFO_AW] != r_ptr[FIFO_AW])
                   && (w_ptr[FIFO_AW-1:0] == r_ptr[FIFO_AW-1:0]);
    assign pop   = ~nextdata_n & ready;
    assign data  = mem[r_ptr[FIFO_AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            w_ptr    <= '0;
            r_ptr    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (pop)
            begin
                r_ptr    <= r_ptr + 1'b1;
                overflow <= 1'b0;
            end
            if (wr_en)
            begin
                if (full)
                    overflow <= 1'b1;  // code lost
                else
                    w_ptr <= w_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en && !full)
            mem[w_ptr[FIFO_AW-1:0]] <= wr_data;
    end

endmodule

// ==== logic/kbd_pkg.sv ====
package kbd_pkg;

    localparam int FRAME_BITS      = 11;
    localparam int FIFO_DEPTH      = 8;
    localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
    localparam int PS2_IDLE_CYCLES = 400;
    localparam int IDLE_CNT_W      = $clog2(PS2_IDLE_CYCLES);

    localparam logic [7:0] BREAK_PREFIX = 8'hF0;
    localparam logic [7:0] SEG_BLANK    = 8'hFF;  // all segments off, dp off

    // start bit arrives first and ends up in bit 0
    typedef struct packed {
        logic       stop;
        logic       parity;
        logic [7:0] data;
        logic       start;
    } ps2_fields_t;

    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        ps2_fields_t           f;
    } ps2_frame_u;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        MAKE,
        BREAK_WAIT,
        BREAK_CODE,
        RELEASE
    } kbd_state_e;

endpackage
